//--- rtl/port_pkg.sv
// shared priority types and arbiter state encoding, imported by every module of the egress port
package port_pkg;

    // eight priorities, higher number is more urgent
    localparam int prio_width = 3;
    localparam int num_prios = 8;

    typedef logic [prio_width-1:0] prio_t;

    // one bit per priority
    typedef logic [num_prios-1:0] prio_mask_t;

    // complete packets waiting in one priority
    typedef logic [5:0] pkt_count_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ADDR,
        ARB_STREAM,
        ARB_DONE
    } arb_state_t;

endpackage

//--- rtl/packet_buffer.sv
// packet word memory split into one circular region per priority, written and read by the queue manager
`timescale 1ns/1ns

module packet_buffer
    import port_pkg::*;
#(
    parameter int data_width = 64,
    parameter int region_addr_width = 5
) (
    input  logic                                  clk,
    input  logic                                  wr_en,
    input  logic [prio_width+region_addr_width-1:0] wr_addr,
    input  logic [data_width-1:0]                 wr_word,
    input  logic                                  wr_last,
    input  logic [prio_width+region_addr_width-1:0] rd_addr,
    output logic [data_width-1:0]                 rd_word,
    output logic                                  rd_last
);

    localparam int depth = num_prios << region_addr_width;

    // end-of-packet flag kept in the top bit of each entry
    logic [data_width:0] mem [depth];
    logic [data_width:0] rd_entry;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= {wr_last, wr_word};
        end
        rd_entry <= mem[rd_addr];
    end

    assign rd_word = rd_entry[data_width-1:0];
    assign rd_last = rd_entry[data_width];

endmodule

//--- rtl/priority_queue_manager.sv
// per-priority queue pointers and packet counts, maps writes into regions and drives buffer reads
`timescale 1ns/1ns

module priority_queue_manager
    import port_pkg::*;
#(
    parameter int data_width = 64,
    parameter int region_addr_width = 5
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    wr_vld,
    input  logic [data_width-1:0]                   wr_data,
    input  prio_t                                   wr_prio,
    input  logic                                    wr_eop,
    input  prio_mask_t                              next_data,
    input  logic                                    rd_request,
    input  logic                                    pkt_done,
    output prio_mask_t                              prepared,
    output logic                                    buf_wr_en,
    output logic [prio_width+region_addr_width-1:0] buf_wr_addr,
    output logic [data_width-1:0]                   buf_wr_word,
    output logic                                    buf_wr_last,
    output logic [prio_width+region_addr_width-1:0] buf_rd_addr
);

    typedef logic [region_addr_width-1:0] offset_t;

    offset_t    wr_ptr [num_prios];
    offset_t    rd_ptr [num_prios];
    pkt_count_t count [num_prios];

    // selected priority decoded from the one-hot select
    prio_t      sel_prio;
    // priority of the packet in flight, kept after next_data drops
    prio_t      cur_prio;
    offset_t    issued_off;
    prio_mask_t inc_mask;
    prio_mask_t dec_mask;

    always_comb begin
        sel_prio = '0;
        for (int i = 0; i < num_prios; i++) begin
            if (next_data[i]) begin
                sel_prio = prio_t'(i);
            end
        end
    end

    // write side goes straight into the region of the packet's priority
    assign buf_wr_en   = wr_vld;
    assign buf_wr_addr = {wr_prio, wr_ptr[wr_prio]};
    assign buf_wr_word = wr_data;
    assign buf_wr_last = wr_eop;

    assign buf_rd_addr = {sel_prio, rd_ptr[sel_prio]};

    // a packet counts once its last word is in the buffer
    assign inc_mask = (wr_vld && wr_eop) ? prio_mask_t'(1) << wr_prio : '0;
    assign dec_mask = pkt_done ? prio_mask_t'(1) << cur_prio : '0;

    always_comb begin
        for (int i = 0; i < num_prios; i++) begin
            prepared[i] = count[i] != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_prios; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                count[i]  <= '0;
            end
            cur_prio   <= '0;
            issued_off <= '0;
        end else begin
            if (wr_vld) begin
                wr_ptr[wr_prio] <= wr_ptr[wr_prio] + 1'b1;
            end

            if (rd_request) begin
                rd_ptr[sel_prio] <= rd_ptr[sel_prio] + 1'b1;
                issued_off       <= rd_ptr[sel_prio];
                cur_prio         <= sel_prio;
            end else if (pkt_done) begin
                // last issued address was the speculative one past the eop word
                rd_ptr[cur_prio] <= issued_off;
            end

            for (int i = 0; i < num_prios; i++) begin
                if (inc_mask[i] && !dec_mask[i]) begin
                    count[i] <= count[i] + 1'b1;
                end else if (dec_mask[i] && !inc_mask[i]) begin
                    count[i] <= count[i] - 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/read_arbiter.sv
// picks the next priority by strict priority or weighted round robin and frames packets on the output
`timescale 1ns/1ns

module read_arbiter
    import port_pkg::*;
#(
    parameter int data_width = 64,
    parameter int wrr_weight_width = 5
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ready,
    input  logic                        sp0_wrr1,
    input  logic [wrr_weight_width-1:0] wrr_weight,
    input  prio_mask_t                  prepared,
    input  logic [data_width-1:0]       rd_word,
    input  logic                        rd_last,
    output prio_mask_t                  next_data,
    output logic                        rd_request,
    output logic                        pkt_done,
    output logic [data_width-1:0]       rd_data,
    output logic                        rd_vld,
    output logic                        rd_sop,
    output logic                        rd_eop
);

    arb_state_t                  state;
    logic                        first_word;

    // wrr position, priority being served and packets taken from it
    prio_t                       wrr_prio;
    logic [wrr_weight_width-1:0] wrr_served;
    logic [wrr_weight_width-1:0] eff_weight;
    logic                        wrr_stay;
    prio_t                       wrr_next;
    prio_t                       sp_pick;
    prio_t                       pick;

    // highest prepared priority
    always_comb begin
        sp_pick = '0;
        for (int i = 0; i < num_prios; i++) begin
            if (prepared[i]) begin
                sp_pick = prio_t'(i);
            end
        end
    end

    // nearest lower prepared priority with wrap, the farthest is scanned first
    always_comb begin
        prio_t cand;
        wrr_next = wrr_prio;
        for (int i = num_prios; i >= 1; i--) begin
            cand = wrr_prio - prio_t'(i);
            if (prepared[cand]) begin
                wrr_next = cand;
            end
        end
    end

    // a weight of zero still serves one packet
    assign eff_weight = (wrr_weight == '0) ? 1 : wrr_weight;
    assign wrr_stay   = prepared[wrr_prio] && (wrr_served < eff_weight);
    assign pick       = sp0_wrr1 ? (wrr_stay ? wrr_prio : wrr_next) : sp_pick;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ARB_IDLE;
            next_data  <= '0;
            rd_request <= 1'b0;
            pkt_done   <= 1'b0;
            rd_vld     <= 1'b0;
            rd_sop     <= 1'b0;
            rd_eop     <= 1'b0;
            first_word <= 1'b0;
            wrr_prio   <= prio_t'(num_prios - 1);
            wrr_served <= '0;
        end else begin
            rd_vld   <= 1'b0;
            rd_sop   <= 1'b0;
            rd_eop   <= 1'b0;
            pkt_done <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    // ready only matters here, between packets
                    if (ready && |prepared) begin
                        state      <= ARB_ADDR;
                        next_data  <= prio_mask_t'(1) << pick;
                        rd_request <= 1'b1;
                        if (sp0_wrr1) begin
                            if (wrr_stay) begin
                                wrr_served <= wrr_served + 1'b1;
                            end else begin
                                wrr_prio   <= wrr_next;
                                wrr_served <= 1;
                            end
                        end
                    end
                end
                ARB_ADDR: begin
                    // first address in flight, its word returns next cycle
                    state      <= ARB_STREAM;
                    first_word <= 1'b1;
                end
                ARB_STREAM: begin
                    rd_vld     <= 1'b1;
                    rd_sop     <= first_word;
                    rd_eop     <= rd_last;
                    first_word <= 1'b0;
                    if (rd_last) begin
                        state      <= ARB_DONE;
                        rd_request <= 1'b0;
                        next_data  <= '0;
                        pkt_done   <= 1'b1;
                    end
                end
                ARB_DONE: begin
                    state <= ARB_IDLE;
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_STREAM) begin
            rd_data <= rd_word;
        end
    end

endmodule

//--- rtl/output_port.sv
// egress port top level, joins queue manager, packet buffer and read arbiter
`timescale 1ns/1ns

module output_port
    import port_pkg::*;
#(
    parameter int data_width = 64,
    parameter int region_addr_width = 5,
    parameter int wrr_weight_width = 5
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr_vld,
    input  logic [data_width-1:0]       wr_data,
    input  prio_t                       wr_prio,
    input  logic                        wr_eop,
    input  logic                        ready,
    input  logic                        sp0_wrr1,
    input  logic [wrr_weight_width-1:0] wrr_weight,
    output logic [data_width-1:0]       rd_data,
    output logic                        rd_vld,
    output logic                        rd_sop,
    output logic                        rd_eop
);

    prio_mask_t                              prepared;
    prio_mask_t                              next_data;
    logic                                    rd_request;
    logic                                    pkt_done;
    logic                                    buf_wr_en;
    logic [prio_width+region_addr_width-1:0] buf_wr_addr;
    logic [data_width-1:0]                   buf_wr_word;
    logic                                    buf_wr_last;
    logic [prio_width+region_addr_width-1:0] buf_rd_addr;
    logic [data_width-1:0]                   buf_rd_word;
    logic                                    buf_rd_last;

    priority_queue_manager #(
        .data_width        (data_width),
        .region_addr_width (region_addr_width)
    ) u_manager (
        .clk         (clk),
        .rst         (rst),
        .wr_vld      (wr_vld),
        .wr_data     (wr_data),
        .wr_prio     (wr_prio),
        .wr_eop      (wr_eop),
        .next_data   (next_data),
        .rd_request  (rd_request),
        .pkt_done    (pkt_done),
        .prepared    (prepared),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_word (buf_wr_word),
        .buf_wr_last (buf_wr_last),
        .buf_rd_addr (buf_rd_addr)
    );

    packet_buffer #(
        .data_width        (data_width),
        .region_addr_width (region_addr_width)
    ) u_buffer (
        .clk     (clk),
        .wr_en   (buf_wr_en),
        .wr_addr (buf_wr_addr),
        .wr_word (buf_wr_word),
        .wr_last (buf_wr_last),
        .rd_addr (buf_rd_addr),
        .rd_word (buf_rd_word),
        .rd_last (buf_rd_last)
    );

    read_arbiter #(
        .data_width       (data_width),
        .wrr_weight_width (wrr_weight_width)
    ) u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .ready      (ready),
        .sp0_wrr1   (sp0_wrr1),
        .wrr_weight (wrr_weight),
        .prepared   (prepared),
        .rd_word    (buf_rd_word),
        .rd_last    (buf_rd_last),
        .next_data  (next_data),
        .rd_request (rd_request),
        .pkt_done   (pkt_done),
        .rd_data    (rd_data),
        .rd_vld     (rd_vld),
        .rd_sop     (rd_sop),
        .rd_eop     (rd_eop)
    );

endmodule

//--- test/tb_output_port.sv
// testbench for the egress port, drives packets in and checks output order and framing against a model
`timescale 1ns/1ns

module tb_output_port
    import port_pkg::*;
;
    logic        clk;
    logic        rst;
    logic        wr_vld;
    logic [63:0] wr_data;
    prio_t       wr_prio;
    logic        wr_eop;
    logic        ready;
    logic        sp0_wrr1;
    logic [4:0]  wrr_weight;
    logic [63:0] rd_data;
    logic        rd_vld;
    logic        rd_sop;
    logic        rd_eop;

    // model storage, 32 words and 32 packet records per priority
    logic [64:0] mword [256];
    int          pavail [256];
    int          wr_idx [8];
    int          rd_idx [8];
    int          p_wr [8];
    int          p_rd [8];
    int          cycle = 0;
    int          sop_count = 0;
    logic        in_pkt = 1'b0;
    logic [3:0]  ready_hist = '0;
    prio_t       cur_prio = '0;
    prio_t       wrr_cur = 3'd7;
    int          wrr_count = 0;
    logic [64:0] exp_word;
    logic [15:0] seq = '0;
    logic [31:0] lfsr = 32'he3b0;

    output_port #(
        .data_width        (64),
        .region_addr_width (5),
        .wrr_weight_width  (5)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .wr_vld     (wr_vld),
        .wr_data    (wr_data),
        .wr_prio    (wr_prio),
        .wr_eop     (wr_eop),
        .ready      (ready),
        .sp0_wrr1   (sp0_wrr1),
        .wrr_weight (wrr_weight),
        .rd_data    (rd_data),
        .rd_vld     (rd_vld),
        .rd_sop     (rd_sop),
        .rd_eop     (rd_eop)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_failed();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
        $display("[ERROR] time %0t signal %s expected %h actual %h", $time, name, exp, got);
        stop_failed();
    endtask

    task automatic report_failure(input string msg);
        $display("time %0t: %s", $time, msg);
        stop_failed();
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // priorities whose oldest packet was complete at the pick edge
    function automatic prio_mask_t eligible_mask();
        prio_mask_t m;
        for (int p = 0; p < 8; p++) begin
            m[p] = (p_wr[p] > p_rd[p]) && (pavail[p * 32 + p_rd[p] % 32] <= cycle);
        end
        return m;
    endfunction

    // model pick, replays strict priority and wrr rotation
    task automatic start_packet();
        prio_mask_t elig;
        prio_t      pick;
        logic       found;
        int         weight;
        elig = eligible_mask();
        assert (rd_sop) else report_mismatch("rd_sop", 64'd1, 64'(rd_sop));
        assert (ready_hist[3]) else report_failure("packet started while ready was low");
        assert (elig != '0) else report_failure("packet started with nothing queued");
        pick = '0;
        for (int p = 0; p < 8; p++) begin
            if (elig[p]) begin
                pick = prio_t'(p);
            end
        end
        if (sp0_wrr1) begin
            weight = (wrr_weight == '0) ? 1 : int'(wrr_weight);
            if (elig[wrr_cur] && wrr_count < weight) begin
                pick = wrr_cur;
                wrr_count++;
            end else begin
                found = 1'b0;
                for (int i = 1; i <= 8; i++) begin
                    if (!found && elig[prio_t'(wrr_cur - i)]) begin
                        pick  = prio_t'(wrr_cur - i);
                        found = 1'b1;
                    end
                end
                wrr_cur   = pick;
                wrr_count = 1;
            end
        end
        cur_prio = pick;
        p_rd[pick]++;
        sop_count++;
    endtask

    // outputs are sampled on the falling edge, away from the driving edge
    always @(negedge clk) begin
        ready_hist = {ready_hist[2:0], ready};
        if (rst) begin
            in_pkt = 1'b0;
        end else if (rd_vld) begin
            if (!in_pkt) begin
                start_packet();
            end else begin
                assert (!rd_sop) else report_mismatch("rd_sop", 64'd0, 64'(rd_sop));
            end
            exp_word = mword[cur_prio * 32 + rd_idx[cur_prio] % 32];
            assert (rd_data == exp_word[63:0])
                else report_mismatch("rd_data", exp_word[63:0], rd_data);
            assert (rd_eop == exp_word[64])
                else report_mismatch("rd_eop", 64'(exp_word[64]), 64'(rd_eop));
            rd_idx[cur_prio]++;
            in_pkt = !exp_word[64];
        end else begin
            assert (!in_pkt) else report_failure("rd_vld dropped inside a packet");
            assert (!rd_sop && !rd_eop) else report_failure("rd_sop or rd_eop without rd_vld");
        end
    end

    task automatic wait_for_space(input prio_t prio, input int len);
        int waited;
        waited = 0;
        while (wr_idx[prio] - rd_idx[prio] + len > 32) begin
            @(posedge clk);
            waited++;
            if (waited > 2000) begin
                report_failure("priority region never had room for the next packet");
            end
        end
    endtask

    task automatic send_packet(input prio_t prio, input int len);
        logic [63:0] data;
        wait_for_space(prio, len);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            data = {8'(prio), seq, rand_bits(32), 8'(i)};
            wr_vld  <= 1'b1;
            wr_data <= data;
            wr_prio <= prio;
            wr_eop  <= (i == len - 1);
            mword[prio * 32 + wr_idx[prio] % 32] = {(i == len - 1), data};
            wr_idx[prio]++;
        end
        // counted one edge after the eop write, picked the edge after, sop two edges later
        pavail[prio * 32 + p_wr[prio] % 32] = cycle + 5;
        p_wr[prio]++;
        seq++;
        @(posedge clk);
        wr_vld <= 1'b0;
        wr_eop <= 1'b0;
    endtask

    task automatic random_packet();
        prio_t prio;
        int    len;
        int    tries;
        prio  = prio_t'(rand_bits(3));
        len   = 1 + int'(rand_bits(8)) % 6;
        tries = 0;
        while (wr_idx[prio] - rd_idx[prio] + len > 32 && tries < 8) begin
            prio = prio - 1'b1;
            tries++;
        end
        send_packet(prio, len);
    endtask

    task automatic set_ready(input logic value);
        @(posedge clk);
        ready <= value;
    endtask

    task automatic wait_for_sop();
        int start;
        int waited;
        start  = sop_count;
        waited = 0;
        while (sop_count == start) begin
            @(posedge clk);
            waited++;
            if (waited > 300) begin
                report_failure("no packet started on the output");
            end
        end
    endtask

    task automatic wait_drained();
        int   waited;
        logic busy;
        waited = 0;
        busy   = 1'b1;
        while (busy) begin
            @(posedge clk);
            busy = in_pkt;
            for (int p = 0; p < 8; p++) begin
                if (p_rd[p] != p_wr[p]) begin
                    busy = 1'b1;
                end
            end
            waited++;
            if (waited > 5000) begin
                report_failure("queued packets never left the output port");
            end
        end
        repeat (4) @(posedge clk);
    endtask

    initial begin
        rst        = 1'b1;
        wr_vld     = 1'b0;
        wr_data    = '0;
        wr_prio    = '0;
        wr_eop     = 1'b0;
        ready      = 1'b0;
        sp0_wrr1   = 1'b0;
        wrr_weight = '0;
        for (int p = 0; p < 8; p++) begin
            wr_idx[p] = 0;
            rd_idx[p] = 0;
            p_wr[p]   = 0;
            p_rd[p]   = 0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // packets stored while ready stays low, nothing may come out
        repeat (8) random_packet();
        repeat (40) @(posedge clk);
        assert (sop_count == 0) else report_failure("output started while ready was low");

        // strict priority drain, then writes continuing during reads
        set_ready(1'b1);
        wait_drained();
        repeat (20) random_packet();
        wait_drained();

        // late high priority packet overtakes waiting low ones
        set_ready(1'b0);
        repeat (4) send_packet(3'd1, 5);
        set_ready(1'b1);
        wait_for_sop();
        send_packet(3'd6, 3);
        wait_drained();

        for (int w = 1; w <= 3; w++) begin
            @(posedge clk);
            ready      <= 1'b0;
            sp0_wrr1   <= 1'b1;
            wrr_weight <= 5'(w);
            repeat (12) random_packet();
            set_ready(1'b1);
            repeat (6) random_packet();
            wait_drained();
        end

        // ready dropped mid packet
        @(posedge clk);
        ready    <= 1'b0;
        sp0_wrr1 <= 1'b0;
        repeat (3) send_packet(prio_t'(rand_bits(3)), 6);
        set_ready(1'b1);
        wait_for_sop();
        set_ready(1'b0);
        repeat (30) @(posedge clk);
        assert (!in_pkt) else report_failure("packet did not finish after ready dropped");
        assert (sop_count < int'(seq)) else report_failure("all packets left while ready was low");
        set_ready(1'b1);
        wait_drained();

        $display("No errors");
        $finish;
    end

endmodule

//--- project.f
rtl/port_pkg.sv
rtl/packet_buffer.sv
rtl/priority_queue_manager.sv
rtl/read_arbiter.sv
rtl/output_port.sv
test/tb_output_port.sv

//--- Bender.yml
package:
  name: output_port

sources:
  - rtl/port_pkg.sv
  - rtl/packet_buffer.sv
  - rtl/priority_queue_manager.sv
  - rtl/read_arbiter.sv
  - rtl/output_port.sv
  - target: test
    files:
      - test/tb_output_port.sv
